// File: include/engine_defs.svh
// Width and count macros shared by the read/write engine RTL and testbench

`ifndef ENGINE_DEFS_SVH
`define ENGINE_DEFS_SVH

// Packet layout
`define ENGINE_NUM_FIELDS 4
`define ENGINE_FIELD_W    32

// Memory request address
`define ENGINE_OFFSET_W   32

// Granularity shift amount, enough for any shift of a 32-bit offset
`define ENGINE_SHIFT_W    5

// Channel and buffer tags
`define ENGINE_ID_W       4

// Burst length field
`define ENGINE_BURST_W    8

`endif

// File: rtl/engine_pkg.sv
// Packet, configuration, address and request types of the read/write engine

`include "engine_defs.svh"

package engine_pkg;

  // ----------------------------------------------------------------------
  // Engine packet
  // ----------------------------------------------------------------------

  typedef struct packed {
    logic [`ENGINE_NUM_FIELDS-1:0][`ENGINE_FIELD_W-1:0] field;
  } engine_packet_t;

  // ----------------------------------------------------------------------
  // Run configuration, held steady while config_valid is high
  // ----------------------------------------------------------------------

  typedef struct packed {
    // One bit per output field, set means take const_value
    logic [`ENGINE_NUM_FIELDS-1:0]                         const_mask;
    // Row per output field, one-hot input select
    logic [`ENGINE_NUM_FIELDS-1:0][`ENGINE_NUM_FIELDS-1:0] ops_mask;
    logic [`ENGINE_FIELD_W-1:0]                            const_value;
    logic [`ENGINE_OFFSET_W-1:0]                           index_start;
    logic [`ENGINE_SHIFT_W-1:0]                            granularity;
    // 1 shifts left, 0 shifts right
    logic                                                  direction;
    // Field that supplies the offset
    logic [$clog2(`ENGINE_NUM_FIELDS)-1:0]                 offset_field;
    logic [`ENGINE_ID_W-1:0]                               id_channel;
    logic [`ENGINE_ID_W-1:0]                               id_buffer;
  } rw_config_t;

  // ----------------------------------------------------------------------
  // Memory request
  // ----------------------------------------------------------------------

  typedef struct packed {
    logic [`ENGINE_OFFSET_W-1:0] offset;
    logic [`ENGINE_SHIFT_W-1:0]  shift_amount;
    logic                        direction;
    logic [`ENGINE_ID_W-1:0]     id_channel;
    logic [`ENGINE_ID_W-1:0]     id_buffer;
    // Always one, single-beat requests only
    logic [`ENGINE_BURST_W-1:0]  burst_length;
  } request_address_t;

  typedef struct packed {
    request_address_t address;
    engine_packet_t   data;
  } rw_request_t;

endpackage : engine_pkg

// File: rtl/align_stage.sv
// Register chain that delays any payload type by a fixed number of cycles

module align_stage #(
  parameter type T          = logic,
  parameter int  DEPTH      = 1,
  parameter bit  RESET_ZERO = 1'b0
) (
  input  logic ap_clk,
  input  logic areset,
  input  T     din,
  output T     dout
);

  // Stage 0 takes din, the last stage feeds dout
  T stage_q [DEPTH];

  // ----------------------------------------------------------------------
  // Shift chain
  // ----------------------------------------------------------------------

  always_ff @(posedge ap_clk) begin
    if (RESET_ZERO && areset) begin
      // Flush everything in flight, valid bits must not survive reset
      for (int i = 0; i < DEPTH; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= din;
      for (int i = 1; i < DEPTH; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign dout = stage_q[DEPTH-1];

endmodule : align_stage

// File: rtl/offset_address_gen.sv
// Address path: offset field plus start index, then scaled by granularity
// Two register stages, tags taken from the configuration

`include "engine_defs.svh"

module offset_address_gen (
  input  logic                         ap_clk,
  input  engine_pkg::rw_config_t       cfg,
  input  engine_pkg::engine_packet_t   data_in,
  output engine_pkg::request_address_t addr
);

  logic [`ENGINE_OFFSET_W-1:0] offset_sel;
  logic [`ENGINE_OFFSET_W-1:0] sum_q;
  logic [`ENGINE_OFFSET_W-1:0] offset_shifted;

  engine_pkg::request_address_t addr_q;

  // ----------------------------------------------------------------------
  // Stage 1: field select and base add
  // ----------------------------------------------------------------------

  // Field and offset are both 32 bits, sum wraps
  assign offset_sel = data_in.field[cfg.offset_field];

  always_ff @(posedge ap_clk) begin
    sum_q <= cfg.index_start + offset_sel;
  end

  // ----------------------------------------------------------------------
  // Stage 2: granularity shift and request tags
  // ----------------------------------------------------------------------

  always_comb begin
    if (cfg.direction) begin
      offset_shifted = sum_q << cfg.granularity;
    end else begin
      offset_shifted = sum_q >> cfg.granularity;
    end
  end

  always_ff @(posedge ap_clk) begin
    addr_q.offset       <= offset_shifted;
    addr_q.shift_amount <= cfg.granularity;
    addr_q.direction    <= cfg.direction;
    addr_q.id_channel   <= cfg.id_channel;
    addr_q.id_buffer    <= cfg.id_buffer;
    // Single-beat request
    addr_q.burst_length <= `ENGINE_BURST_W'(1);
  end

  // Unqualified here; the combiner decides what reaches the output
  assign addr = addr_q;

endmodule : offset_address_gen

// File: rtl/field_crossbar.sv
// Data path crossbar: per-field input select with constant substitution
// One register stage

`include "engine_defs.svh"

module field_crossbar (
  input  logic                       ap_clk,
  input  engine_pkg::rw_config_t     cfg,
  input  engine_pkg::engine_packet_t data_in,
  output engine_pkg::engine_packet_t routed
);

  engine_pkg::engine_packet_t routed_next;
  engine_pkg::engine_packet_t routed_q;

  // ----------------------------------------------------------------------
  // Field routing
  // ----------------------------------------------------------------------

  always_comb begin
    routed_next = '0;
    for (int i = 0; i < `ENGINE_NUM_FIELDS; i++) begin
      if (cfg.const_mask[i]) begin
        routed_next.field[i] = cfg.const_value;
      end else begin
        // Rows are one-hot so an OR over the selected inputs picks one field
        // An empty row leaves the field at zero
        for (int j = 0; j < `ENGINE_NUM_FIELDS; j++) begin
          if (cfg.ops_mask[i][j]) begin
            routed_next.field[i] = routed_next.field[i] | data_in.field[j];
          end
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Output register
  // ----------------------------------------------------------------------

  always_ff @(posedge ap_clk) begin
    routed_q <= routed_next;
  end

  assign routed = routed_q;

endmodule : field_crossbar

// File: rtl/request_combiner.sv
// Joins aligned address and data into one registered request
// Request is held at zero on every cycle without a valid packet

module request_combiner (
  input  logic                         ap_clk,
  input  logic                         areset,
  input  logic                         valid_aligned,
  input  engine_pkg::request_address_t addr,
  input  engine_pkg::engine_packet_t   routed_aligned,
  output logic                         request_valid,
  output engine_pkg::rw_request_t      request
);

  logic                    request_valid_q;
  engine_pkg::rw_request_t request_q;

  // ----------------------------------------------------------------------
  // Valid strobe
  // ----------------------------------------------------------------------

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      request_valid_q <= 1'b0;
    end else begin
      request_valid_q <= valid_aligned;
    end
  end

  // ----------------------------------------------------------------------
  // Request payload
  // ----------------------------------------------------------------------

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      request_q <= '0;
    end else if (valid_aligned) begin
      request_q.address <= addr;
      request_q.data    <= routed_aligned;
    end else begin
      // Idle cycle, nothing stale leaks to the memory side
      request_q <= '0;
    end
  end

  assign request_valid = request_valid_q;
  assign request       = request_q;

endmodule : request_combiner

// File: rtl/parallel_read_write_engine.sv
// Vertex engine read/write block: address path, data crossbar, alignment
// and request combiner, fixed 3-cycle latency

module parallel_read_write_engine (
  input  logic                       ap_clk,
  input  logic                       areset,
  input  logic                       config_valid,
  input  engine_pkg::rw_config_t     cfg,
  input  logic                       data_valid,
  input  engine_pkg::engine_packet_t data_in,
  output logic                       request_valid,
  output engine_pkg::rw_request_t    request
);

  engine_pkg::request_address_t addr;
  engine_pkg::engine_packet_t   routed;
  engine_pkg::engine_packet_t   routed_aligned;
  logic                         valid_in;
  logic                         valid_aligned;

  // Packets outside a configured run are dropped
  assign valid_in = data_valid & config_valid;

  // ----------------------------------------------------------------------
  // Address path, 2 cycles
  // ----------------------------------------------------------------------

  offset_address_gen u_offset_address_gen (
    .ap_clk  (ap_clk),
    .cfg     (cfg),
    .data_in (data_in),
    .addr    (addr)
  );

  // ----------------------------------------------------------------------
  // Data path, crossbar plus one alignment register
  // ----------------------------------------------------------------------

  field_crossbar u_field_crossbar (
    .ap_clk  (ap_clk),
    .cfg     (cfg),
    .data_in (data_in),
    .routed  (routed)
  );

  align_stage #(
    .T          (engine_pkg::engine_packet_t),
    .DEPTH      (1),
    .RESET_ZERO (1'b0)
  ) u_align_data (
    .ap_clk (ap_clk),
    .areset (areset),
    .din    (routed),
    .dout   (routed_aligned)
  );

  // Valid bit matches the 2-cycle address path
  align_stage #(
    .T          (logic),
    .DEPTH      (2),
    .RESET_ZERO (1'b1)
  ) u_align_valid (
    .ap_clk (ap_clk),
    .areset (areset),
    .din    (valid_in),
    .dout   (valid_aligned)
  );

  request_combiner u_request_combiner (
    .ap_clk         (ap_clk),
    .areset         (areset),
    .valid_aligned  (valid_aligned),
    .addr           (addr),
    .routed_aligned (routed_aligned),
    .request_valid  (request_valid),
    .request        (request)
  );

endmodule : parallel_read_write_engine

// File: tb/engine_properties.sv
// Concurrent checks on the read/write engine top level ports

`include "engine_defs.svh"

module engine_properties (
  input logic                    ap_clk,
  input logic                    areset,
  input logic                    config_valid,
  input logic                    data_valid,
  input logic                    request_valid,
  input engine_pkg::rw_request_t request
);
  timeunit 1ns;
  timeprecision 1ps;

  // ----------------------------------------------------------------------
  // Reset and idle behavior
  // ----------------------------------------------------------------------

  // Strobe is flushed by every reset edge
  reset_quiet: assert property (@(posedge ap_clk) $past(areset) |-> !request_valid)
    else $error("request_valid high during reset or in the cycle after it");

  idle_zero: assert property (@(posedge ap_clk) disable iff (areset)
    !request_valid |-> request == '0)
    else $error("request not zero while request_valid is low");

  single_beat: assert property (@(posedge ap_clk) disable iff (areset)
    request_valid |-> request.address.burst_length == `ENGINE_BURST_W'(1))
    else $error("burst_length differs from one on a valid request");

  // ----------------------------------------------------------------------
  // Fixed latency
  // ----------------------------------------------------------------------

  // Packets caught by a reset edge are flushed, so skip windows touching one
  fixed_latency: assert property (@(posedge ap_clk) disable iff (areset)
    (!$past(areset, 1) && !$past(areset, 2) && !$past(areset, 3))
    |-> request_valid == $past(data_valid && config_valid, 3))
    else $error("request_valid does not follow an accepted packet by 3 cycles");

endmodule : engine_properties

// File: tb/tb_parallel_read_write_engine.sv
// Testbench for the parallel read/write engine with random stimulus, reference
// model, expected queue, fixed-latency checks and summary

`include "engine_defs.svh"

module tb_parallel_read_write_engine;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int SEL_W      = $clog2(`ENGINE_NUM_FIELDS);
  localparam int T1_CYCLES  = 150;
  localparam int T2_CYCLES  = 150;
  localparam int T3_RUNS    = 4;
  localparam int T3_LEN     = 40;
  localparam int T4_RUNS    = 6;
  localparam int T4_LEN     = 30;
  localparam int T5_ROUNDS  = 3;
  localparam int T5_LEN     = 20;
  localparam int RESET_LEN  = 2;
  // Config change plus drain per run
  localparam int SETTLE     = 12;
  localparam int TIMEOUT_CYCLES = 8 + T1_CYCLES + T2_CYCLES + T3_RUNS * T3_LEN
    + T4_RUNS * T4_LEN + T5_ROUNDS * (2 * T5_LEN + RESET_LEN + 1)
    + (T3_RUNS + 4) * SETTLE + 200;

  logic                       ap_clk;
  logic                       areset;
  logic                       config_valid;
  engine_pkg::rw_config_t     cfg;
  logic                       data_valid;
  engine_pkg::engine_packet_t data_in;
  logic                       request_valid;
  engine_pkg::rw_request_t    request;

  logic [31:0] lcg_state = 32'hf5c6_2039;
  int          cycle_count = 0;
  int          check_count = 0;
  int          error_count = 0;

  engine_pkg::rw_request_t expected_q[$];
  int                      due_q[$];

  parallel_read_write_engine dut0 (
    .ap_clk        (ap_clk),
    .areset        (areset),
    .config_valid  (config_valid),
    .cfg           (cfg),
    .data_valid    (data_valid),
    .data_in       (data_in),
    .request_valid (request_valid),
    .request       (request)
  );

  bind parallel_read_write_engine engine_properties u_engine_properties (
    .ap_clk        (ap_clk),
    .areset        (areset),
    .config_valid  (config_valid),
    .data_valid    (data_valid),
    .request_valid (request_valid),
    .request       (request)
  );

  initial begin
    ap_clk = 1'b0;
    forever #10 ap_clk = ~ap_clk;
  end

  // ----------------------------------------------------------------------
  // Random sources
  // ----------------------------------------------------------------------

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    // Fold the high half down since low LCG bits repeat quickly
    return lcg_state ^ {16'h0000, lcg_state[31:16]};
  endfunction

  function automatic logic chance(input int pct);
    return int'(next_random() % 32'd100) < pct;
  endfunction

  function automatic engine_pkg::engine_packet_t random_packet();
    engine_pkg::engine_packet_t p;
    for (int i = 0; i < `ENGINE_NUM_FIELDS; i++) begin
      p.field[i] = next_random();
    end
    return p;
  endfunction

  function automatic engine_pkg::rw_config_t random_config(input int empty_pct);
    engine_pkg::rw_config_t c;
    logic [31:0]            r;
    c = '0;
    for (int i = 0; i < `ENGINE_NUM_FIELDS; i++) begin
      r = next_random();
      if (!chance(empty_pct)) begin
        c.ops_mask[i][r[SEL_W-1:0]] = 1'b1;
      end
    end
    r = next_random();
    c.const_mask   = r[`ENGINE_NUM_FIELDS-1:0];
    c.granularity  = r[8 +: `ENGINE_SHIFT_W];
    c.direction    = r[16];
    c.offset_field = r[20 +: SEL_W];
    c.id_channel   = r[24 +: `ENGINE_ID_W];
    c.id_buffer    = r[28 +: `ENGINE_ID_W];
    c.const_value  = next_random();
    c.index_start  = next_random();
    return c;
  endfunction

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------

  function automatic engine_pkg::rw_request_t model_request(
    input engine_pkg::rw_config_t     c,
    input engine_pkg::engine_packet_t p
  );
    engine_pkg::rw_request_t     r;
    logic [`ENGINE_OFFSET_W-1:0] base;
    r = '0;
    for (int i = 0; i < `ENGINE_NUM_FIELDS; i++) begin
      if (c.const_mask[i]) begin
        r.data.field[i] = c.const_value;
      end else begin
        // Empty row keeps zero
        for (int j = 0; j < `ENGINE_NUM_FIELDS; j++) begin
          if (c.ops_mask[i][j]) begin
            r.data.field[i] = p.field[j];
          end
        end
      end
    end
    base = c.index_start + p.field[c.offset_field];
    if (c.direction) begin
      r.address.offset = base << c.granularity;
    end else begin
      r.address.offset = base >> c.granularity;
    end
    r.address.shift_amount = c.granularity;
    r.address.direction    = c.direction;
    r.address.id_channel   = c.id_channel;
    r.address.id_buffer    = c.id_buffer;
    r.address.burst_length = `ENGINE_BURST_W'(1);
    return r;
  endfunction

  // ----------------------------------------------------------------------
  // Monitor and scoreboard
  // ----------------------------------------------------------------------

  always @(posedge ap_clk) begin : monitor
    engine_pkg::rw_request_t exp;
    int                      due;
    cycle_count = cycle_count + 1;
    if (request_valid === 1'b1) begin
      if (expected_q.size() == 0) begin
        $display("Unexpected request at %0t with no packet outstanding", $time);
        error_count++;
      end else begin
        exp = expected_q.pop_front();
        due = due_q.pop_front();
        check_count++;
        if (due != cycle_count) begin
          $display("Request at %0t came on cycle %0d instead of cycle %0d",
                   $time, cycle_count, due);
          error_count++;
        end
        if (request.address !== exp.address) begin
          $display("[ERROR] %0t: address %h, expected %h",
                   $time, request.address, exp.address);
          error_count++;
        end
        if (request.data !== exp.data) begin
          $display("[ERROR] %0t: data %h, expected %h", $time, request.data, exp.data);
          error_count++;
        end
      end
    end else if (due_q.size() != 0 && due_q[0] <= cycle_count) begin
      $display("Missing request at %0t for a packet due on cycle %0d", $time, due_q[0]);
      error_count++;
      void'(expected_q.pop_front());
      void'(due_q.pop_front());
    end
    // Reset drops everything in flight
    if (areset === 1'b1) begin
      expected_q.delete();
      due_q.delete();
    end else if (data_valid && config_valid) begin
      expected_q.push_back(model_request(cfg, data_in));
      due_q.push_back(cycle_count + 3);
    end
  end

  initial begin : watchdog
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Done: errors found");
    $finish;
  end

  // ----------------------------------------------------------------------
  // Stimulus tasks
  // ----------------------------------------------------------------------

  // Config only changes while nothing is in flight
  task automatic apply_config(input engine_pkg::rw_config_t c);
    @(posedge ap_clk);
    config_valid <= 1'b0;
    data_valid   <= 1'b0;
    repeat (4) @(posedge ap_clk);
    cfg          <= c;
    config_valid <= 1'b1;
  endtask

  task automatic send_packets(input int n, input int valid_pct);
    for (int k = 0; k < n; k++) begin
      @(posedge ap_clk);
      data_valid <= chance(valid_pct);
      data_in    <= random_packet();
    end
  endtask

  task automatic drain();
    @(posedge ap_clk);
    data_valid <= 1'b0;
    // The edge above can still accept the last packet
    @(posedge ap_clk);
    while (expected_q.size() != 0) begin
      @(posedge ap_clk);
    end
    repeat (2) @(posedge ap_clk);
  endtask

  task automatic report_test(input string name, input int checks0, input int errors0);
    $display("Test %s finished: %0d requests checked, %0d errors",
             name, check_count - checks0, error_count - errors0);
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------

  initial begin : main
    engine_pkg::rw_config_t c;
    int                     checks0;
    int                     errors0;
    areset       = 1'b1;
    config_valid = 1'b0;
    cfg          = '0;
    data_valid   = 1'b0;
    data_in      = '0;
    repeat (8) @(posedge ap_clk);
    areset <= 1'b0;

    // Routing only, one packet per cycle
    checks0 = check_count;
    errors0 = error_count;
    c = random_config(0);
    c.const_mask = '0;
    apply_config(c);
    send_packets(T1_CYCLES, 100);
    drain();
    report_test("routing", checks0, errors0);

    // Constants and empty rows
    checks0 = check_count;
    errors0 = error_count;
    apply_config(random_config(25));
    send_packets(T2_CYCLES, 75);
    drain();
    report_test("constant", checks0, errors0);

    // Address path over several configs
    checks0 = check_count;
    errors0 = error_count;
    for (int r = 0; r < T3_RUNS; r++) begin
      apply_config(random_config(0));
      send_packets(T3_LEN, 90);
      drain();
    end
    report_test("address", checks0, errors0);

    // config_valid toggles between runs
    checks0 = check_count;
    errors0 = error_count;
    apply_config(random_config(10));
    for (int r = 0; r < T4_RUNS; r++) begin
      @(posedge ap_clk);
      config_valid <= (r % 2) == 1;
      send_packets(T4_LEN, 50);
    end
    @(posedge ap_clk);
    config_valid <= 1'b1;
    drain();
    report_test("gating", checks0, errors0);

    // Reset with packets in flight
    checks0 = check_count;
    errors0 = error_count;
    apply_config(random_config(0));
    for (int r = 0; r < T5_ROUNDS; r++) begin
      send_packets(T5_LEN, 80);
      @(posedge ap_clk);
      areset <= 1'b1;
      send_packets(RESET_LEN, 80);
      @(posedge ap_clk);
      areset <= 1'b0;
      send_packets(T5_LEN, 80);
    end
    drain();
    report_test("reset", checks0, errors0);

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule : tb_parallel_read_write_engine

// File: verilog.f
+incdir+include
rtl/engine_pkg.sv
rtl/align_stage.sv
rtl/offset_address_gen.sv
rtl/field_crossbar.sv
rtl/request_combiner.sv
rtl/parallel_read_write_engine.sv
tb/engine_properties.sv
tb/tb_parallel_read_write_engine.sv

// File: Makefile
# Verilator simulation of the parallel read/write engine

VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_parallel_read_write_engine
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
